// File: sim.f
jpeg_rle_pkg.sv
dc_diff_predictor.sv
coeff_run_encoder.sv
zero_run_suppressor.sv
jpeg_rle_top.sv
tb_jpeg_rle.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_jpeg_rle

if ! out=$(./obj_dir/Vtb_jpeg_rle 2>&1); then
	echo "$out"
	echo "simulator exited with an error"
	exit 1
fi
echo "$out"

grep -q "Simulation completed successfully" <<< "$out"

// File: tb_jpeg_rle.sv
`timescale 1ns/1ps

module tb_jpeg_rle;
	import jpeg_rle_pkg::*;

	localparam int DRAIN_LIMIT = 400;	// enabled cycles to empty the expected queue

	logic                     clk;
	logic                     rst;
	logic                     ena;
	logic                     restart;
	logic                     coef_valid;
	logic signed [COEF_W-1:0] coef;
	logic                     tok_valid;
	rle_token_t               tok;

	rle_token_t  exp_q [$];	// tokens still owed by the dut
	int          blk [64];	// block under construction, zig-zag order
	int          model_pred;	// dc of the previous block
	int          exp_count;
	int          rcv_count;
	int          value_errs;
	int          other_errs;
	logic [31:0] rng_state;

	jpeg_rle_top #(
		.ZRL_DEPTH (4)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.ena        (ena),
		.restart    (restart),
		.coef_valid (coef_valid),
		.coef       (coef),
		.tok_valid  (tok_valid),
		.tok        (tok)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// bit length of |v|
	function automatic int magnitude_bits(input int v);
		int m;
		int n;
		m = (v < 0) ? -v : v;
		n = 0;
		while (m > 0)
		begin
			n = n + 1;
			m = m >> 1;
		end
		return n;
	endfunction

	function automatic logic [AMP_W-1:0] ones_comp_amp(input int v);
		int n;
		n = magnitude_bits(v);
		if (v >= 0)
			return AMP_W'(v);
		return AMP_W'(((1 << n) - 1) - (-v));	// magnitude inverted in n bits
	endfunction

	function automatic rle_token_t make_tok(input logic dc, input int rlen, input int v);
		rle_token_t t;
		t.dc   = dc;
		t.rlen = 4'(rlen);
		t.size = 4'(magnitude_bits(v));
		t.amp  = ones_comp_amp(v);
		return t;
	endfunction

	task automatic push_exp(input rle_token_t t);
		exp_q.push_back(t);
		exp_count = exp_count + 1;
	endtask

	task automatic check_token(input rle_token_t exp_tok, input rle_token_t got_tok);
		if (got_tok !== exp_tok)
		begin
			$display("CHECK FAILED at %0t: token %0d expected dc=%0b run=%0d size=%0d amp=%03h",
				$time, rcv_count, exp_tok.dc, exp_tok.rlen, exp_tok.size, exp_tok.amp);
			$display("    got dc=%0b run=%0d size=%0d amp=%03h",
				got_tok.dc, got_tok.rlen, got_tok.size, got_tok.amp);
			value_errs = value_errs + 1;
		end
	endtask

	task automatic check_count(input int exp_n, input int got_n, input string what);
		if (got_n != exp_n)
		begin
			$display("CHECK FAILED at %0t: %s token count expected %0d got %0d",
				$time, what, exp_n, got_n);
			value_errs = value_errs + 1;
		end
	endtask

	// expected tokens of blk, straight from the coding rules
	task automatic model_block();
		int run;
		int held;
		push_exp(make_tok(1'b1, 0, blk[0] - model_pred));
		model_pred = blk[0];
		run        = 0;
		held       = 0;
		for (int p = 1; p < 64; p++)
		begin
			if (blk[p] != 0)
			begin
				for (int k = 0; k < held; k++)
					push_exp(make_tok(1'b0, 15, 0));	// zrl released
				held = 0;
				push_exp(make_tok(1'b0, run, blk[p]));
				run = 0;
			end
			else if (p == 63)
				push_exp(make_tok(1'b0, 0, 0));	// eob, held zrls vanish
			else if (run == 15)
			begin
				held = held + 1;
				run  = 0;
			end
			else
				run = run + 1;
		end
	endtask

	task automatic clear_block();
		for (int p = 0; p < 64; p++)
			blk[p] = 0;
	endtask

	task automatic send_block(input bit stall);
		model_block();
		for (int p = 0; p < 64; p++)
		begin
			if (stall && (p % 9 == 4))
			begin
				ena        = 1'b0;
				coef_valid = 1'b1;	// garbage while disabled
				coef       = COEF_W'(-777);
				repeat (2)
				begin
					@(posedge clk);
					#1;
				end
				ena = 1'b1;
			end
			coef_valid = 1'b1;
			coef       = COEF_W'(blk[p]);
			@(posedge clk);
			#1;
		end
		coef_valid = 1'b0;
	endtask

	task automatic do_restart();
		restart    = 1'b1;
		coef_valid = 1'b0;
		@(posedge clk);
		#1;
		restart    = 1'b0;
		model_pred = 0;
	endtask

	task automatic wait_drain(input string name, input int base_exp, input int base_rcv);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT)
		begin
			@(posedge clk);
			#1;
			n = n + 1;
		end
		if (exp_q.size() != 0)
		begin
			$display("ERROR at %0t: timeout in %s, %0d expected tokens never came out",
				$time, name, exp_q.size());
			other_errs = other_errs + 1;
			exp_q.delete();
		end
		repeat (6)
		begin
			@(posedge clk);	// room for a stray extra token
			#1;
		end
		check_count(exp_count - base_exp, rcv_count - base_rcv, name);
	endtask

	// each token is counted on the enabled edge that consumes it
	always @(posedge clk)
	begin
		if (rst && ena && tok_valid)
		begin
			rcv_count = rcv_count + 1;
			if (exp_q.size() == 0)
			begin
				$display("ERROR at %0t: DUT produced a token when none was expected", $time);
				other_errs = other_errs + 1;
			end
			else
				check_token(exp_q.pop_front(), tok);
		end
	end

	task automatic dc_only_blocks();
		int base_exp;
		int base_rcv;
		base_exp = exp_count;
		base_rcv = rcv_count;
		clear_block();
		blk[0] = 100;
		send_block(1'b0);
		blk[0] = -37;
		send_block(1'b0);
		blk[0] = 250;
		send_block(1'b0);
		check_count(6, exp_count - base_exp, "dc differencing model");
		wait_drain("dc differencing", base_exp, base_rcv);
	endtask

	task automatic scattered_ac_block();
		int base_exp;
		int base_rcv;
		base_exp = exp_count;
		base_rcv = rcv_count;
		clear_block();
		blk[0]  = 12;
		blk[1]  = 5;
		blk[2]  = -3;
		blk[6]  = 1;
		blk[10] = -1;
		blk[20] = 255;
		blk[33] = -512;
		blk[40] = 1023;
		blk[47] = -1024;
		blk[63] = -7;	// run of exactly 15, nonzero last
		send_block(1'b0);
		check_count(10, exp_count - base_exp, "run/size/amp model");
		wait_drain("run/size/amp", base_exp, base_rcv);
	endtask

	task automatic long_run_block();
		int base_exp;
		int base_rcv;
		base_exp = exp_count;
		base_rcv = rcv_count;
		clear_block();
		blk[0]  = 3;
		blk[21] = 9;	// 20 zeros ahead of it
		send_block(1'b0);
		check_count(4, exp_count - base_exp, "zrl kept model");
		wait_drain("zrl kept", base_exp, base_rcv);
	endtask

	task automatic trailing_zeros_block();
		int base_exp;
		int base_rcv;
		base_exp = exp_count;
		base_rcv = rcv_count;
		clear_block();
		blk[0] = -5;
		blk[5] = -2;
		send_block(1'b0);
		check_count(3, exp_count - base_exp, "zrl suppressed model");
		wait_drain("zrl suppressed", base_exp, base_rcv);
	endtask

	task automatic restart_and_stall();
		int base_exp;
		int base_rcv;
		base_exp = exp_count;
		base_rcv = rcv_count;
		clear_block();
		blk[0] = 40;
		blk[3] = 7;
		send_block(1'b0);
		do_restart();
		clear_block();
		blk[0]  = -60;	// diff is the raw value after restart
		blk[17] = -33;
		blk[50] = 2;
		send_block(1'b1);
		check_count(10, exp_count - base_exp, "restart/enable model");
		wait_drain("restart/enable", base_exp, base_rcv);
	endtask

	task automatic random_blocks();
		logic [31:0] r;
		int          base_exp;
		int          base_rcv;
		base_exp = exp_count;
		base_rcv = rcv_count;
		for (int b = 0; b < 20; b++)
		begin
			for (int p = 0; p < 64; p++)
			begin
				r = xorshift32();
				if (p == 0)
					blk[p] = int'(r[20:10]) - 1024;
				else if ((b % 2 == 0) ? (r[2:0] == 3'd0) : (r[3:0] == 4'd0))
					blk[p] = int'(r[19:10]) - 512;	// odd blocks sparser, longer runs
				else
					blk[p] = 0;
			end
			send_block(1'b0);
		end
		wait_drain("random blocks", base_exp, base_rcv);
	endtask

	initial
	begin
		rst        = 1'b0;
		ena        = 1'b0;
		restart    = 1'b0;
		coef_valid = 1'b0;
		coef       = '0;
		model_pred = 0;
		exp_count  = 0;
		rcv_count  = 0;
		value_errs = 0;
		other_errs = 0;
		rng_state  = 32'hb5fd;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b1;
		ena = 1'b1;

		dc_only_blocks();
		scattered_ac_block();
		long_run_block();
		trailing_zeros_block();
		restart_and_stall();
		random_blocks();

		$display("tb_jpeg_rle: %0d tokens, %0d value errors, %0d other errors",
			rcv_count, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: jpeg_rle_top.sv
`timescale 1ns/1ps

module jpeg_rle_top #(
	parameter int ZRL_DEPTH = 4	// three pending zrls plus the releasing token
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   ena,
	input  logic                                   restart,
	input  logic                                   coef_valid,
	input  logic signed [jpeg_rle_pkg::COEF_W-1:0] coef,
	output logic                                   tok_valid,
	output jpeg_rle_pkg::rle_token_t               tok
);
	import jpeg_rle_pkg::*;

	logic       diff_valid;
	coef_word_t diff;	// dc-differenced coefficient
	logic       rz_valid;
	rle_token_t rz_tok;	// raw tokens, zrls not yet suppressed

	dc_diff_predictor dc_i (
		.clk        (clk),
		.rst        (rst),
		.ena        (ena),
		.restart    (restart),
		.coef_valid (coef_valid),
		.coef       (coef),
		.diff_valid (diff_valid),
		.diff       (diff)
	);

	coeff_run_encoder enc_i (
		.clk        (clk),
		.rst        (rst),
		.ena        (ena),
		.diff_valid (diff_valid),
		.diff       (diff),
		.rz_valid   (rz_valid),
		.rz_tok     (rz_tok)
	);

	zero_run_suppressor #(
		.ZRL_DEPTH (ZRL_DEPTH)
	) rzs_i (
		.clk       (clk),
		.rst       (rst),
		.ena       (ena),
		.rz_valid  (rz_valid),
		.rz_tok    (rz_tok),
		.tok_valid (tok_valid),
		.tok       (tok)
	);

endmodule

// File: zero_run_suppressor.sv
`timescale 1ns/1ps

module zero_run_suppressor #(
	parameter int ZRL_DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ena,
	input  logic                     rz_valid,
	input  jpeg_rle_pkg::rle_token_t rz_tok,
	output logic                     tok_valid,
	output jpeg_rle_pkg::rle_token_t tok
);
	import jpeg_rle_pkg::*;

	localparam int CNT_W = $clog2(ZRL_DEPTH + 1);

	rle_token_t       q [ZRL_DEPTH-1];	// tokens waiting behind the output register
	logic [CNT_W-1:0] q_lvl;
	logic [CNT_W-1:0] held;	// zrls not yet known to be needed
	logic [CNT_W-1:0] held_nxt;
	rle_token_t       comb_q [ZRL_DEPTH];	// queue after this cycle's writes
	logic [CNT_W:0]   comb_lvl;
	logic             in_zrl;
	logic             in_eob;

	assign in_zrl = !rz_tok.dc && (rz_tok.rlen == 4'hf) && (rz_tok.size == 4'h0);
	assign in_eob = !rz_tok.dc && (rz_tok.rlen == 4'h0) && (rz_tok.size == 4'h0);

	always_comb
	begin
		int add;
		add      = 0;
		held_nxt = held;
		comb_lvl = (CNT_W+1)'(q_lvl);
		for (int i = 0; i < ZRL_DEPTH - 1; i++)
			comb_q[i] = q[i];
		comb_q[ZRL_DEPTH-1] = '0;
		if (rz_valid)
		begin
			if (in_zrl)
				held_nxt = held + 1'b1;	// hold until the block's fate is known
			else
			begin
				if (!in_eob)
					add = int'(held);	// eob drops them, anything else releases
				for (int i = 0; i < ZRL_DEPTH; i++)
				begin
					if (i >= int'(q_lvl) && i < int'(q_lvl) + add)
						comb_q[i] = TOK_ZRL;
					else if (i == int'(q_lvl) + add)
						comb_q[i] = rz_tok;
				end
				comb_lvl = (CNT_W+1)'(int'(q_lvl) + add + 1);
				held_nxt = '0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			tok_valid <= 1'b0;
			q_lvl     <= '0;
			held      <= '0;
		end
		else if (ena)
		begin
			tok_valid <= (comb_lvl != '0);
			q_lvl     <= (comb_lvl != '0) ? CNT_W'(comb_lvl - 1'b1) : '0;	// head leaves
			held      <= held_nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ena)
		begin
			if (comb_lvl != '0)
				tok <= comb_q[0];
			for (int i = 0; i < ZRL_DEPTH - 1; i++)
				q[i] <= comb_q[i + 1];	// shift toward the head
		end
	end

	// zrls come 16 inputs apart, so the queue drains in time
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst)
		ena |-> (comb_lvl <= (CNT_W+1)'(ZRL_DEPTH) && held < CNT_W'(ZRL_DEPTH))
	) else $error("held zrl queue overflow");

	// a block never starts with zrls still held from the one before
	a_no_held_at_dc: assert property (
		@(posedge clk) disable iff (!rst)
		(ena && rz_valid && rz_tok.dc) |-> (held == '0)
	) else $error("held zrls met a dc token");

endmodule

// File: coeff_run_encoder.sv
`timescale 1ns/1ps

module coeff_run_encoder (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ena,
	input  logic                     diff_valid,
	input  jpeg_rle_pkg::coef_word_t diff,
	output logic                     rz_valid,
	output jpeg_rle_pkg::rle_token_t rz_tok
);
	import jpeg_rle_pkg::*;

	logic [3:0] run;	// zero ACs pending since the last token
	logic [3:0] run_nxt;
	logic       val_zero;
	logic       emit;
	logic [3:0] val_size;
	logic [AMP_W-1:0] val_amp;
	rle_token_t nxt_tok;

	assign val_zero = (diff.val == '0);
	assign val_size = coef_size(diff.val);
	assign val_amp  = coef_amp(diff.val);

	always_comb
	begin
		emit    = 1'b0;
		nxt_tok = TOK_EOB;
		run_nxt = run;
		if (diff.dc)
		begin
			// dc always goes out, even when the difference is zero
			emit         = 1'b1;
			nxt_tok.dc   = 1'b1;
			nxt_tok.rlen = 4'd0;
			nxt_tok.size = val_size;
			nxt_tok.amp  = val_amp;
			run_nxt      = 4'd0;
		end
		else if (!val_zero)
		begin
			emit         = 1'b1;
			nxt_tok.rlen = run;
			nxt_tok.size = val_size;
			nxt_tok.amp  = val_amp;
			run_nxt      = 4'd0;
		end
		else if (diff.last)
		begin
			emit    = 1'b1;	// trailing zeros collapse into eob
			nxt_tok = TOK_EOB;
			run_nxt = 4'd0;
		end
		else if (run == 4'd15)
		begin
			emit    = 1'b1;	// 16th zero of the run
			nxt_tok = TOK_ZRL;
			run_nxt = 4'd0;
		end
		else
		begin
			run_nxt = run + 4'd1;
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			run      <= 4'd0;
			rz_valid <= 1'b0;
		end
		else if (ena)
		begin
			rz_valid <= diff_valid & emit;
			if (diff_valid)
				run <= run_nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ena && diff_valid && emit)
			rz_tok <= nxt_tok;
	end

	// every block ends in eob or a nonzero last, so a new dc sees no zeros
	a_dc_clean_run: assert property (
		@(posedge clk) disable iff (!rst)
		(ena && diff_valid && diff.dc) |-> (run == 4'd0)
	) else $error("zero run pending at the start of a block");

endmodule

// File: dc_diff_predictor.sv
`timescale 1ns/1ps

module dc_diff_predictor (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   ena,
	input  logic                                   restart,
	input  logic                                   coef_valid,
	input  logic signed [jpeg_rle_pkg::COEF_W-1:0] coef,
	output logic                                   diff_valid,
	output jpeg_rle_pkg::coef_word_t               diff
);
	import jpeg_rle_pkg::*;

	logic [5:0]              pos;	// zig-zag position of the next coefficient
	logic signed [COEF_W-1:0] pred;	// dc of the previous block
	logic [5:0]              cur_pos;
	logic signed [COEF_W-1:0] cur_pred;
	logic signed [AMP_W-1:0]  coef_ext;
	logic signed [AMP_W-1:0]  pred_ext;
	logic                    is_dc;

	// a restart in the same cycle as a coefficient acts first
	assign cur_pos  = restart ? 6'd0 : pos;
	assign cur_pred = restart ? '0 : pred;
	assign coef_ext = AMP_W'(coef);	// sign extension
	assign pred_ext = AMP_W'(cur_pred);
	assign is_dc    = (cur_pos == 6'd0);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			pos        <= 6'd0;
			pred       <= '0;
			diff_valid <= 1'b0;
		end
		else if (ena)
		begin
			diff_valid <= coef_valid;
			if (restart)
			begin
				pos  <= 6'd0;
				pred <= '0;
			end
			if (coef_valid)
			begin
				pos <= cur_pos + 6'd1;	// wraps to 0 after position 63
				if (is_dc)
					pred <= coef;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (ena && coef_valid)
		begin
			diff.dc   <= is_dc;
			diff.last <= (cur_pos == 6'd63);
			diff.pos  <= cur_pos;
			diff.val  <= is_dc ? (coef_ext - pred_ext) : coef_ext;
		end
	end

	// restart is only legal on a block boundary
	a_restart_between_blocks: assert property (
		@(posedge clk) disable iff (!rst)
		(ena && restart) |-> (pos == 6'd0)
	) else $error("restart arrived in the middle of a block");

endmodule

// File: jpeg_rle_pkg.sv
package jpeg_rle_pkg;

	localparam int COEF_W = 11;	// quantized input coefficient, signed
	localparam int AMP_W  = 12;	// amplitude and dc difference

	// one coefficient word between stages
	typedef struct packed {
		logic                    dc;	// first coefficient of a block
		logic                    last;	// 64th coefficient of a block
		logic [5:0]              pos;	// zig-zag index
		logic signed [AMP_W-1:0] val;
	} coef_word_t;

	// one run/size/amplitude token
	typedef struct packed {
		logic             dc;
		logic [3:0]       rlen;
		logic [3:0]       size;
		logic [AMP_W-1:0] amp;
	} rle_token_t;

	localparam rle_token_t TOK_ZRL = '{dc: 1'b0, rlen: 4'hf, size: 4'h0, amp: '0};
	localparam rle_token_t TOK_EOB = '{dc: 1'b0, rlen: 4'h0, size: 4'h0, amp: '0};

	// bit length of the magnitude, 0 for zero
	function automatic logic [3:0] coef_size(input logic signed [AMP_W-1:0] v);
		logic [AMP_W-1:0] mag;
		logic [3:0]       sz;
		mag = v[AMP_W-1] ? AMP_W'(-v) : AMP_W'(v);
		sz  = 4'd0;
		for (int i = 0; i < AMP_W; i++)
			if (mag[i])
				sz = 4'(i + 1);	// highest set bit wins
		return sz;
	endfunction

	// negative values go out as one's complement in the low size bits
	function automatic logic [AMP_W-1:0] coef_amp(input logic signed [AMP_W-1:0] v);
		logic [3:0]       sz;
		logic [AMP_W-1:0] mask;
		logic [AMP_W-1:0] vm1;
		sz   = coef_size(v);
		mask = (AMP_W'(1) << sz) - AMP_W'(1);
		vm1  = AMP_W'(v - 1);
		return v[AMP_W-1] ? (vm1 & mask) : AMP_W'(v);
	endfunction

endpackage
